// File: rtl/btb_geom_pkg.sv
// BTB pc geometry

package btb_geom_pkg;

    // --------------------------------------------------
    // pc split: tag | set index | byte offset
    // --------------------------------------------------
    localparam int pc_w      = 32;
    localparam int off_w     = 2;                      // word aligned fetch
    localparam int idx_w     = 9;
    localparam int tag_w     = pc_w - idx_w - off_w;   // 21 bits
    localparam int set_count = 1 << idx_w;             // 512 sets
    localparam int target_w  = 32;

    typedef struct packed {
        logic [tag_w-1:0] tag;
        logic [idx_w-1:0] index;
        logic [off_w-1:0] offset;
    } btb_pc_fields_t;

    // same fetch word, seen raw or split into fields
    typedef union packed {
        logic [pc_w-1:0] raw;
        btb_pc_fields_t  f;
    } btb_pc_u;

endpackage

// File: rtl/btb_entry_pkg.sv
// BTB way and PLRU definitions

package btb_entry_pkg;

    localparam int way_count = 4;
    localparam int way_idx_w = $clog2(way_count);
    localparam int plru_w    = 3;   // bit0 half, bit1 ways 0-1, bit2 ways 2-3

    // --------------------------------------------------
    // tree PLRU helpers
    // --------------------------------------------------

    // mark one way as most recently used, untouched branch keeps its value
    function automatic logic [plru_w-1:0] plru_touch(input logic [way_idx_w-1:0] way,
                                                     input logic [plru_w-1:0] old);
        logic [plru_w-1:0] state;
        state = old;
        case (way)
            way_idx_w'(0): begin
                state[0] = 1'b1;    // victim now in upper half
                state[1] = 1'b1;
            end
            way_idx_w'(1): begin
                state[0] = 1'b1;
                state[1] = 1'b0;
            end
            way_idx_w'(2): begin
                state[0] = 1'b0;    // victim now in lower half
                state[2] = 1'b1;
            end
            default: begin
                state[0] = 1'b0;
                state[2] = 1'b0;
            end
        endcase
        return state;
    endfunction

    // way the tree points at
    function automatic logic [way_idx_w-1:0] plru_victim(input logic [plru_w-1:0] state);
        if (state[0])
            return state[2] ? way_idx_w'(3) : way_idx_w'(2);
        return state[1] ? way_idx_w'(1) : way_idx_w'(0);
    endfunction

endpackage

// File: rtl/btb_way_ram.sv
// BTB way storage
`timescale 1ns/10ps

module btb_way_ram (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [btb_geom_pkg::idx_w-1:0]    rd_index,
    input  logic                              wr_en,
    input  logic [btb_geom_pkg::idx_w-1:0]    wr_index,
    input  logic [btb_geom_pkg::tag_w-1:0]    wr_tag,
    input  logic [btb_geom_pkg::target_w-1:0] wr_target,
    output logic                              rd_valid,
    output logic [btb_geom_pkg::tag_w-1:0]    rd_tag,
    output logic [btb_geom_pkg::target_w-1:0] rd_target
);
    import btb_geom_pkg::*;

    logic [tag_w-1:0]    tag_mem    [set_count];
    logic [target_w-1:0] target_mem [set_count];
    logic [set_count-1:0] valid_q;                 // one flop per set

    // --------------------------------------------------
    // tag and target array, registered read
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_index]    <= wr_tag;
            target_mem[wr_index] <= wr_target;
        end
        rd_tag    <= tag_mem[rd_index];             // old data on same-entry write
        rd_target <= target_mem[rd_index];
    end

    // valid bits live outside the RAM so reset can clear them
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q  <= '0;
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= valid_q[rd_index];
            if (wr_en) begin
                valid_q[wr_index] <= 1'b1;
            end
        end
    end

    // no write request while in reset
    a_no_write_in_reset: assert property (@(posedge clk)
        !rst_n |-> !wr_en)
        else $error("way written while in reset");

endmodule

// File: rtl/btb_plru_ram.sv
// BTB PLRU state storage
`timescale 1ns/10ps

module btb_plru_ram (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [btb_geom_pkg::idx_w-1:0]    rd_index,
    input  logic                              wr_en,
    input  logic [btb_geom_pkg::idx_w-1:0]    wr_index,
    input  logic [btb_entry_pkg::plru_w-1:0]  wr_plru,
    output logic [btb_entry_pkg::plru_w-1:0]  rd_plru
);
    import btb_geom_pkg::*;
    import btb_entry_pkg::*;

    logic [plru_w-1:0] plru_q [set_count];     // flop array, cleared on reset

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            plru_q  <= '{default: '0};
            rd_plru <= '0;
        end else begin
            rd_plru <= plru_q[rd_index];        // old state on same-set write
            if (wr_en) begin
                plru_q[wr_index] <= wr_plru;
            end
        end
    end

endmodule

// File: rtl/btb_victim_select.sv
// BTB update way select
`timescale 1ns/10ps

module btb_victim_select (
    input  logic                                update,
    input  logic [btb_geom_pkg::pc_w-1:0]       pc,
    input  logic [btb_geom_pkg::tag_w-1:0]      block0_tag_id,
    input  logic [btb_geom_pkg::tag_w-1:0]      block1_tag_id,
    input  logic [btb_geom_pkg::tag_w-1:0]      block2_tag_id,
    input  logic [btb_geom_pkg::tag_w-1:0]      block3_tag_id,
    input  logic [btb_entry_pkg::way_count-1:0] way_valid_id,
    input  logic [btb_entry_pkg::plru_w-1:0]    plru_data_id,
    output logic [btb_entry_pkg::way_count-1:0] way_wr,
    output logic [btb_entry_pkg::plru_w-1:0]    write_plru
);
    import btb_geom_pkg::*;
    import btb_entry_pkg::*;

    btb_pc_u               pc_u;
    logic [way_count-1:0]  match;       // copied ways already holding this branch
    logic [way_idx_w-1:0]  sel_way;

    assign pc_u.raw = pc;

    assign match[0] = way_valid_id[0] && (block0_tag_id == pc_u.f.tag);
    assign match[1] = way_valid_id[1] && (block1_tag_id == pc_u.f.tag);
    assign match[2] = way_valid_id[2] && (block2_tag_id == pc_u.f.tag);
    assign match[3] = way_valid_id[3] && (block3_tag_id == pc_u.f.tag);

    // --------------------------------------------------
    // rewrite a matching way, else replace the PLRU victim
    // --------------------------------------------------
    always_comb begin
        if (match[0]) begin
            sel_way = way_idx_w'(0);
        end else if (match[1]) begin
            sel_way = way_idx_w'(1);
        end else if (match[2]) begin
            sel_way = way_idx_w'(2);
        end else if (match[3]) begin
            sel_way = way_idx_w'(3);
        end else begin
            sel_way = plru_victim(plru_data_id);    // state as seen at lookup
        end

        write_plru = plru_touch(sel_way, plru_data_id);

        way_wr = '0;
        if (update) begin
            way_wr[sel_way] = 1'b1;
        end
    end

endmodule

// File: rtl/btb_hit_select.sv
// BTB lookup hit select
`timescale 1ns/10ps

module btb_hit_select (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [btb_geom_pkg::pc_w-1:0]       pc,
    input  logic                                update,
    input  logic [btb_geom_pkg::tag_w-1:0]      rd_tag0,
    input  logic [btb_geom_pkg::tag_w-1:0]      rd_tag1,
    input  logic [btb_geom_pkg::tag_w-1:0]      rd_tag2,
    input  logic [btb_geom_pkg::tag_w-1:0]      rd_tag3,
    input  logic [btb_geom_pkg::target_w-1:0]   rd_target0,
    input  logic [btb_geom_pkg::target_w-1:0]   rd_target1,
    input  logic [btb_geom_pkg::target_w-1:0]   rd_target2,
    input  logic [btb_geom_pkg::target_w-1:0]   rd_target3,
    input  logic [btb_entry_pkg::way_count-1:0] rd_valid,
    input  logic [btb_entry_pkg::plru_w-1:0]    rd_plru,
    input  logic [btb_entry_pkg::plru_w-1:0]    write_plru,
    output logic [btb_geom_pkg::target_w-1:0]   tar_data,
    output logic                                tar_en,
    output logic                                plru_wr,
    output logic [btb_geom_pkg::idx_w-1:0]      plru_wr_index,
    output logic [btb_entry_pkg::plru_w-1:0]    plru_wr_data
);
    import btb_geom_pkg::*;
    import btb_entry_pkg::*;

    btb_pc_u              pc_u;         // live fetch pc
    btb_pc_u              lk_pc;        // pc lined up with RAM output
    logic                 upd_q;        // previous cycle was an update
    logic [way_count-1:0] match;
    logic [way_idx_w-1:0] hit_way;
    logic [target_w-1:0]  hit_target;

    assign pc_u.raw = pc;

    always_ff @(posedge clk) begin
        lk_pc.raw <= pc;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            upd_q <= 1'b0;
        end else begin
            upd_q <= update;
        end
    end

    // --------------------------------------------------
    // tag compare, lowest way wins
    // --------------------------------------------------
    assign match[0] = rd_valid[0] && (rd_tag0 == lk_pc.f.tag);
    assign match[1] = rd_valid[1] && (rd_tag1 == lk_pc.f.tag);
    assign match[2] = rd_valid[2] && (rd_tag2 == lk_pc.f.tag);
    assign match[3] = rd_valid[3] && (rd_tag3 == lk_pc.f.tag);

    always_comb begin
        hit_way    = way_idx_w'(3);
        hit_target = rd_target3;
        if (match[0]) begin
            hit_way    = way_idx_w'(0);
            hit_target = rd_target0;
        end else if (match[1]) begin
            hit_way    = way_idx_w'(1);
            hit_target = rd_target1;
        end else if (match[2]) begin
            hit_way    = way_idx_w'(2);
            hit_target = rd_target2;
        end
    end

    assign tar_en   = (|match) && !upd_q;       // RAM was busy writing last cycle
    assign tar_data = tar_en ? hit_target : '0;

    // update wins the PLRU port over a hit touch
    always_comb begin
        if (update) begin
            plru_wr       = 1'b1;
            plru_wr_index = pc_u.f.index;
            plru_wr_data  = write_plru;
        end else begin
            plru_wr       = tar_en;
            plru_wr_index = lk_pc.f.index;
            plru_wr_data  = plru_touch(hit_way, rd_plru);
        end
    end

    // update is a one-cycle strobe
    a_update_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        update |=> !update)
        else $error("update held for more than one cycle");

endmodule

// File: rtl/btb_top.sv
// BTB top level
`timescale 1ns/10ps

module btb_top (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [btb_geom_pkg::pc_w-1:0]       pc,
    input  logic                                update,
    input  logic [btb_geom_pkg::target_w-1:0]   tar_addr,
    input  logic [btb_geom_pkg::tag_w-1:0]      block0_tag_id,
    input  logic [btb_geom_pkg::tag_w-1:0]      block1_tag_id,
    input  logic [btb_geom_pkg::tag_w-1:0]      block2_tag_id,
    input  logic [btb_geom_pkg::tag_w-1:0]      block3_tag_id,
    input  logic [btb_entry_pkg::way_count-1:0] way_valid_id,
    input  logic [btb_entry_pkg::plru_w-1:0]    plru_data_id,
    output logic [btb_geom_pkg::target_w-1:0]   tar_data,
    output logic                                tar_en,
    output logic [btb_geom_pkg::tag_w-1:0]      block0_tag,
    output logic [btb_geom_pkg::tag_w-1:0]      block1_tag,
    output logic [btb_geom_pkg::tag_w-1:0]      block2_tag,
    output logic [btb_geom_pkg::tag_w-1:0]      block3_tag,
    output logic [btb_entry_pkg::way_count-1:0] way_valid,
    output logic [btb_entry_pkg::plru_w-1:0]    plru_data
);
    import btb_geom_pkg::*;
    import btb_entry_pkg::*;

    wire [idx_w-1:0]     pc_index = pc[off_w +: idx_w];
    wire [tag_w-1:0]     pc_tag   = pc[pc_w-1 -: tag_w];
    wire [way_count-1:0] way_wr;
    wire [target_w-1:0]  rd_target0, rd_target1, rd_target2, rd_target3;
    wire [plru_w-1:0]    write_plru;
    wire                 plru_wr;
    wire [idx_w-1:0]     plru_wr_index;
    wire [plru_w-1:0]    plru_wr_data;

    // --------------------------------------------------
    // four ways, one read/write index from the pc
    // --------------------------------------------------
    btb_way_ram way0_inst (
        .clk(clk), .rst_n(rst_n), .rd_index(pc_index),
        .wr_en(way_wr[0]), .wr_index(pc_index), .wr_tag(pc_tag), .wr_target(tar_addr),
        .rd_valid(way_valid[0]), .rd_tag(block0_tag), .rd_target(rd_target0)
    );

    btb_way_ram way1_inst (
        .clk(clk), .rst_n(rst_n), .rd_index(pc_index),
        .wr_en(way_wr[1]), .wr_index(pc_index), .wr_tag(pc_tag), .wr_target(tar_addr),
        .rd_valid(way_valid[1]), .rd_tag(block1_tag), .rd_target(rd_target1)
    );

    btb_way_ram way2_inst (
        .clk(clk), .rst_n(rst_n), .rd_index(pc_index),
        .wr_en(way_wr[2]), .wr_index(pc_index), .wr_tag(pc_tag), .wr_target(tar_addr),
        .rd_valid(way_valid[2]), .rd_tag(block2_tag), .rd_target(rd_target2)
    );

    btb_way_ram way3_inst (
        .clk(clk), .rst_n(rst_n), .rd_index(pc_index),
        .wr_en(way_wr[3]), .wr_index(pc_index), .wr_tag(pc_tag), .wr_target(tar_addr),
        .rd_valid(way_valid[3]), .rd_tag(block3_tag), .rd_target(rd_target3)
    );

    btb_plru_ram plru_inst (
        .clk(clk), .rst_n(rst_n), .rd_index(pc_index),
        .wr_en(plru_wr), .wr_index(plru_wr_index), .wr_plru(plru_wr_data),
        .rd_plru(plru_data)
    );

    // --------------------------------------------------
    // update path and lookup path
    // --------------------------------------------------
    btb_victim_select victim_inst (
        .update(update), .pc(pc),
        .block0_tag_id(block0_tag_id), .block1_tag_id(block1_tag_id),
        .block2_tag_id(block2_tag_id), .block3_tag_id(block3_tag_id),
        .way_valid_id(way_valid_id), .plru_data_id(plru_data_id),
        .way_wr(way_wr), .write_plru(write_plru)
    );

    btb_hit_select hit_inst (
        .clk(clk), .rst_n(rst_n), .pc(pc), .update(update),
        .rd_tag0(block0_tag), .rd_tag1(block1_tag),
        .rd_tag2(block2_tag), .rd_tag3(block3_tag),
        .rd_target0(rd_target0), .rd_target1(rd_target1),
        .rd_target2(rd_target2), .rd_target3(rd_target3),
        .rd_valid(way_valid), .rd_plru(plru_data), .write_plru(write_plru),
        .tar_data(tar_data), .tar_en(tar_en),
        .plru_wr(plru_wr), .plru_wr_index(plru_wr_index), .plru_wr_data(plru_wr_data)
    );

endmodule

// File: tests/tb_clock.sv
// Testbench clock source
`timescale 1ns/10ps

module tb_clock (
    output logic clk
);
    localparam real half_period = 2.0;     // 4 ns period

    initial begin
        clk = 1'b0;
    end

    always #(half_period) clk = ~clk;

endmodule

// File: tests/btb_model.svh
// BTB reference model
`ifndef BTB_MODEL_SVH
`define BTB_MODEL_SVH

logic [20:0] mdl_tag    [4][512];
logic [31:0] mdl_target [4][512];
logic        mdl_valid  [4][512];
logic [2:0]  mdl_plru   [512];
logic        prev_en;                  // last result was a hit
logic [8:0]  prev_idx;
logic [1:0]  prev_way;
logic [2:0]  prev_plru;

// bit0 half, bit1 inside ways 0-1, bit2 inside ways 2-3
function automatic logic [2:0] tree_touch(input logic [1:0] way, input logic [2:0] old);
    logic [2:0] s;
    s = old;
    case (way)
        2'd0: s = {s[2], 2'b11};
        2'd1: s = {s[2], 2'b01};
        2'd2: s = {1'b1, s[1], 1'b0};
        default: s = {1'b0, s[1], 1'b0};
    endcase
    return s;
endfunction

function automatic logic [1:0] tree_victim(input logic [2:0] s);
    if (s[0])
        return s[2] ? 2'd3 : 2'd2;
    return s[1] ? 2'd1 : 2'd0;
endfunction

task automatic clear_model();
    for (int s = 0; s < 512; s++) begin
        for (int w = 0; w < 4; w++) begin
            mdl_tag[w][s]    = '0;
            mdl_target[w][s] = '0;
            mdl_valid[w][s]  = 1'b0;
        end
        mdl_plru[s] = '0;
    end
    prev_en   = 1'b0;
    prev_idx  = '0;
    prev_way  = '0;
    prev_plru = '0;
endtask

// one clock edge, inputs as the DUT sees them
task automatic step_model();
    logic [8:0]  idx;
    logic [20:0] tg;
    logic [1:0]  sel;
    logic        hit;
    logic [20:0] id_tag [4];
    idx = pc[10:2];
    tg  = pc[31:11];
    id_tag[0] = block0_tag_id;
    id_tag[1] = block1_tag_id;
    id_tag[2] = block2_tag_id;
    id_tag[3] = block3_tag_id;
    hit = 1'b0;
    exp_way = '0;
    for (int w = 3; w >= 0; w--) begin     // downward so lowest match wins
        exp_valid[w] = mdl_valid[w][idx];
        exp_tag[w]   = mdl_tag[w][idx];
        if (mdl_valid[w][idx] && mdl_tag[w][idx] == tg) begin
            hit = 1'b1;
            exp_way = 2'(w);
        end
    end
    exp_plru      = mdl_plru[idx];
    exp_en        = hit && !update;        // result of an update edge is masked
    exp_data      = exp_en ? mdl_target[exp_way][idx] : '0;
    exp_after_upd = update;
    // ---------------- writes ----------------
    if (update) begin
        sel = tree_victim(plru_data_id);
        for (int w = 3; w >= 0; w--) begin
            if (way_valid_id[w] && id_tag[w] == tg) sel = 2'(w);
        end
        mdl_tag[sel][idx]    = tg;
        mdl_target[sel][idx] = tar_addr;
        mdl_valid[sel][idx]  = 1'b1;
        mdl_plru[idx]        = tree_touch(sel, plru_data_id);
    end else if (prev_en) begin
        mdl_plru[prev_idx] = tree_touch(prev_way, prev_plru);
    end
    prev_en   = exp_en;
    prev_idx  = idx;
    prev_way  = exp_way;
    prev_plru = exp_plru;
endtask

`endif

// File: tests/btb_tb.sv
// BTB testbench
`timescale 1ns/10ps

module btb_tb;
    logic        clk;
    logic        rst_n;
    logic [31:0] pc;
    logic        update;
    logic [31:0] tar_addr;
    logic [20:0] block0_tag_id, block1_tag_id, block2_tag_id, block3_tag_id;
    logic [3:0]  way_valid_id;
    logic [2:0]  plru_data_id;
    logic [31:0] tar_data;
    logic        tar_en;
    logic [20:0] block0_tag, block1_tag, block2_tag, block3_tag;
    logic [3:0]  way_valid;
    logic [2:0]  plru_data;

    // expected result of the last consumed edge
    logic [20:0] exp_tag [4];
    logic [3:0]  exp_valid;
    logic [2:0]  exp_plru;
    logic        exp_en;
    logic [31:0] exp_data;
    logic [1:0]  exp_way;
    logic        exp_after_upd;

    integer seed = 29;
    int errs = 0, test_errs = 0, tests_run = 0, tests_failed = 0;
    logic [31:0] pc_a, tgt, set_pc [5], ev_pc;
    logic [1:0]  vway;
    logic [3:0]  valid_before;
    logic [83:0] tags_before;
    logic [8:0]  pool_idx [4];
    logic [20:0] pool_tag [6];
    logic        ready, last_upd;

    `include "btb_model.svh"

    tb_clock clock_inst (.clk(clk));

    btb_top btb_top_inst (
        .clk(clk), .rst_n(rst_n), .pc(pc), .update(update), .tar_addr(tar_addr),
        .block0_tag_id(block0_tag_id), .block1_tag_id(block1_tag_id),
        .block2_tag_id(block2_tag_id), .block3_tag_id(block3_tag_id),
        .way_valid_id(way_valid_id), .plru_data_id(plru_data_id),
        .tar_data(tar_data), .tar_en(tar_en),
        .block0_tag(block0_tag), .block1_tag(block1_tag),
        .block2_tag(block2_tag), .block3_tag(block3_tag),
        .way_valid(way_valid), .plru_data(plru_data)
    );

    task automatic flag(input string msg);
        $display("ERR %0t: %s", $time, msg);
        errs++;
        test_errs++;
    endtask

    task automatic check_outputs();
        logic [20:0] got_tag [4];
        got_tag = '{block0_tag, block1_tag, block2_tag, block3_tag};
        if (tar_en !== exp_en) flag($sformatf("tar_en %b, expected %b", tar_en, exp_en));
        if (tar_data !== exp_data)
            flag($sformatf("tar_data %h, expected %h", tar_data, exp_data));
        if (way_valid !== exp_valid)
            flag($sformatf("way_valid %b, expected %b", way_valid, exp_valid));
        if (plru_data !== exp_plru)
            flag($sformatf("plru_data %b, expected %b", plru_data, exp_plru));
        for (int w = 0; w < 4; w++) begin
            if (exp_valid[w] && got_tag[w] !== exp_tag[w])
                flag($sformatf("way %0d tag %h, expected %h", w, got_tag[w], exp_tag[w]));
        end
        if (exp_after_upd && tar_en) flag("hit in the cycle after an update");
    endtask

    // consume current inputs at the edge, drive the next ones, check at negedge
    task automatic cycle(input logic [31:0] next_pc, input logic next_upd,
                         input logic [31:0] next_tgt);
        @(posedge clk);
        step_model();
        pc       <= next_pc;
        update   <= next_upd;
        tar_addr <= next_tgt;
        if (next_upd) begin                 // id copies of the previous lookup
            block0_tag_id <= exp_tag[0];
            block1_tag_id <= exp_tag[1];
            block2_tag_id <= exp_tag[2];
            block3_tag_id <= exp_tag[3];
            way_valid_id  <= exp_valid;
            plru_data_id  <= exp_plru;
        end
        @(negedge clk);
        check_outputs();
    endtask

    task automatic branch(input logic [31:0] bpc, input logic [31:0] btgt);
        cycle(bpc, 1'b0, '0);
        cycle(bpc, 1'b1, btgt);
    endtask

    // afterwards the outputs hold the lookup of ppc
    task automatic probe(input logic [31:0] ppc);
        cycle(ppc, 1'b0, '0);
        cycle(ppc, 1'b0, '0);
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errs != 0) begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, test_errs);
        end else begin
            $display("test %s: ok", name);
        end
        test_errs = 0;
    endtask

    // ----------------------------------------------
    // watchdog
    // ----------------------------------------------
    initial begin
        repeat (20000) @(posedge clk);
        $display("simulation ran past its cycle limit");
        $display("Some tests failed");
        $finish;
    end

    initial begin
        rst_n         = 1'b0;
        pc            = '0;
        update        = 1'b0;
        tar_addr      = '0;
        block0_tag_id = '0;
        block1_tag_id = '0;
        block2_tag_id = '0;
        block3_tag_id = '0;
        way_valid_id  = '0;
        plru_data_id  = '0;
        clear_model();
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        ready = 1'b0;
        for (int n = 0; n < 10 && !ready; n++) begin
            cycle('0, 1'b0, '0);
            ready = !tar_en && way_valid == '0 && plru_data == '0;
        end
        if (!ready) begin
            $display("BTB outputs did not settle after reset within 10 cycles");
            errs++;
        end

        // ---------------- after reset ----------------
        for (int n = 0; n < 20; n++) begin
            cycle($random(seed) & 32'hffff_fffc, 1'b0, '0);
            if (tar_en !== 1'b0 || tar_data !== '0 || way_valid !== '0 || plru_data !== '0)
                flag("output not clear after reset");
        end
        finish_test("after reset");

        // ---------------- single branch ----------------
        pc_a = $random(seed) & 32'hffff_fffc;
        tgt  = $random(seed);
        branch(pc_a, tgt);
        probe(pc_a);
        if (!tar_en || tar_data !== tgt) flag("branch not predicted after update");
        finish_test("single branch");

        // ---------------- retarget ----------------
        valid_before = way_valid;
        tags_before  = {block3_tag, block2_tag, block1_tag, block0_tag};
        tgt = $random(seed);
        cycle(pc_a, 1'b1, tgt);             // copies from a fresh lookup of pc_a
        probe(pc_a);
        if (!tar_en || tar_data !== tgt) flag("retarget not seen");
        if (way_valid !== valid_before) flag("retarget changed the valid ways");
        if ({block3_tag, block2_tag, block1_tag, block0_tag} !== tags_before)
            flag("retarget changed a stored tag");
        finish_test("retarget");

        // ---------------- replacement ----------------
        for (int k = 0; k < 5; k++) begin
            set_pc[k] = {21'(k + 100), 9'h0a5, 2'b00};
        end
        for (int k = 0; k < 4; k++) begin
            branch(set_pc[k], 32'h1000 + k);
        end
        cycle(set_pc[4], 1'b0, '0);
        cycle(set_pc[4], 1'b1, 32'h2000);
        vway  = tree_victim(plru_data_id);
        ev_pc = {block0_tag_id, 9'h0a5, 2'b00};
        case (vway)
            2'd1: ev_pc = {block1_tag_id, 9'h0a5, 2'b00};
            2'd2: ev_pc = {block2_tag_id, 9'h0a5, 2'b00};
            2'd3: ev_pc = {block3_tag_id, 9'h0a5, 2'b00};
            default: ;
        endcase
        probe(ev_pc);
        if (tar_en !== 1'b0) flag("evicted branch still hits");
        probe(set_pc[4]);
        if (!tar_en || tar_data !== 32'h2000) flag("new branch missing after replacement");
        finish_test("replacement");

        // ---------------- back-to-back ----------------
        for (int n = 0; n < 60; n++) begin
            cycle(($random(seed) & 1) ? set_pc[$unsigned($random(seed)) % 5] : pc_a,
                  1'b0, '0);
        end
        finish_test("back-to-back lookups");

        // ---------------- random mix ----------------
        pool_idx = '{9'h0a5, 9'h0a6, pc_a[10:2], 9'h003};
        for (int k = 0; k < 6; k++) begin
            pool_tag[k] = 21'($random(seed));
        end
        last_upd = 1'b0;
        for (int n = 0; n < 2000; n++) begin
            if (!last_upd && ($unsigned($random(seed)) % 3 == 0)) begin
                cycle(pc, 1'b1, $random(seed));
                last_upd = 1'b1;
            end else begin
                cycle({pool_tag[$unsigned($random(seed)) % 6],
                       pool_idx[$unsigned($random(seed)) % 4], 2'b00}, 1'b0, '0);
                last_upd = 1'b0;
            end
        end
        finish_test("random mix");

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errs);
        if (errs == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: build.f
rtl/btb_geom_pkg.sv
rtl/btb_entry_pkg.sv
rtl/btb_way_ram.sv
rtl/btb_plru_ram.sv
rtl/btb_victim_select.sv
rtl/btb_hit_select.sv
rtl/btb_top.sv
+incdir+tests
tests/tb_clock.sv
tests/btb_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile with Verilator, run, then search the log for the fail message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f build.f --top-module btb_tb \
    -Mdir obj_dir -o btb_sim > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/btb_sim > sim.log 2>&1
cat sim.log
grep -q "Some tests failed" sim.log && { echo "FAIL"; exit 1; } || \
    grep -q "All tests passed" sim.log && { echo "PASS"; exit 0; } || \
    { echo "FAIL: no result in sim.log"; exit 1; }
